/* Bender.yml */
package:
  name: llc_in_arbiter

sources:
  - llc_in_pkg.sv
  - llc_in_if.sv
  - llc_priority_select.sv
  - llc_decode_fifo.sv
  - llc_set_table.sv
  - llc_line_dispatch.sv
  - llc_in_arbiter.sv
  - target: test
    files:
      - llc_in_arbiter_properties.sv
      - tb_llc_in_arbiter.sv

/* llc_decode_fifo.sv */
/* in-order circular queue of accepted items, head visible one cycle after push
   no overflow or underflow protection, callers honor full and empty */
`timescale 1ns/10ps

module llc_decode_fifo #(
    parameter int DEPTH = 2
) (
    input  logic          clk,
    input  logic          rst,
    decode_push_if.sink   push,
    decode_pop_if.source  pop
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    llc_in_pkg::decode_entry_t mem [DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          count;

    assign push.full = (count == CNT_W'(DEPTH));
    assign pop.empty = (count == '0);
    assign pop.head  = mem[rd_ptr];

    // pointers and occupancy
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push.push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop.pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push.push, pop.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push and pop together
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (push.push) begin
            mem[wr_ptr] <= push.entry;
        end
    end

endmodule

/* llc_in_arbiter.f */
llc_in_pkg.sv
llc_in_if.sv
llc_priority_select.sv
llc_decode_fifo.sv
llc_set_table.sv
llc_line_dispatch.sv
llc_in_arbiter.sv
llc_in_arbiter_properties.sv
tb_llc_in_arbiter.sv

/* llc_in_arbiter.sv */
/* llc input stage, sources hold valid and address until ready
   mem_push comes at the earliest one cycle after acceptance */
`timescale 1ns/10ps

module llc_in_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rst_tb_valid,
    output logic                   rst_tb_ready,
    input  logic                   rsp_valid,
    input  llc_in_pkg::line_addr_t rsp_addr,
    output logic                   rsp_ready,
    input  logic                   req_valid,
    input  llc_in_pkg::line_addr_t req_addr,
    output logic                   req_ready,
    input  logic                   dma_valid,
    input  llc_in_pkg::line_addr_t dma_addr,
    output logic                   dma_ready,
    input  logic                   req_stall,
    input  llc_in_pkg::llc_tag_t   req_stalled_tag,
    input  llc_in_pkg::llc_set_t   req_stalled_set,
    input  logic                   mem_full,
    input  logic                   done_valid,
    input  llc_in_pkg::llc_set_t   done_set,
    output logic                   mem_push,
    output llc_in_pkg::chan_e      mem_chan,
    output llc_in_pkg::llc_tag_t   mem_tag,
    output llc_in_pkg::llc_set_t   mem_set,
    output logic                   clr_req_stall,
    output logic                   idle
);

    decode_push_if push_bus ();
    decode_pop_if  pop_bus ();

    llc_in_pkg::llc_set_t lookup_set;  // also the set booked on add
    logic                 add;
    logic                 hit;
    logic                 table_full;

    llc_priority_select u_select (
        .rst_tb_valid (rst_tb_valid),
        .rsp_valid    (rsp_valid),
        .req_valid    (req_valid),
        .dma_valid    (dma_valid),
        .req_stall    (req_stall),
        .rsp_addr     (rsp_addr),
        .req_addr     (req_addr),
        .dma_addr     (dma_addr),
        .rst_tb_ready (rst_tb_ready),
        .rsp_ready    (rsp_ready),
        .req_ready    (req_ready),
        .dma_ready    (dma_ready),
        .idle         (idle),
        .push         (push_bus.source)
    );

    llc_decode_fifo #(
        .DEPTH (llc_in_pkg::DECODE_DEPTH)
    ) u_fifo (
        .clk  (clk),
        .rst  (rst),
        .push (push_bus.sink),
        .pop  (pop_bus.source)
    );

    llc_set_table #(
        .ENTRIES (llc_in_pkg::SET_TABLE_ENTRIES)
    ) u_set_table (
        .clk        (clk),
        .rst        (rst),
        .lookup_set (lookup_set),
        .add_set    (lookup_set),
        .add        (add),
        .done_valid (done_valid),
        .done_set   (done_set),
        .hit        (hit),
        .table_full (table_full)
    );

    llc_line_dispatch u_dispatch (
        .pop             (pop_bus.sink),
        .mem_full        (mem_full),
        .req_stall       (req_stall),
        .req_stalled_tag (req_stalled_tag),
        .req_stalled_set (req_stalled_set),
        .hit             (hit),
        .table_full      (table_full),
        .lookup_set      (lookup_set),
        .add             (add),
        .mem_push        (mem_push),
        .mem_chan        (mem_chan),
        .mem_tag         (mem_tag),
        .mem_set         (mem_set),
        .clr_req_stall   (clr_req_stall)
    );

endmodule

/* llc_in_arbiter_properties.sv */
/* protocol assertions for the llc input stage, bound into the top level
   all checks are idle while rst is low */
`timescale 1ns/10ps

module llc_in_arbiter_properties (
    input logic clk,
    input logic rst,
    input logic rst_tb_ready,
    input logic rsp_ready,
    input logic req_ready,
    input logic dma_ready,
    input logic mem_push,
    input logic mem_full,
    input logic clr_req_stall
);

    // a single winner per cycle
    a_one_ready: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({rst_tb_ready, rsp_ready, req_ready, dma_ready}))
        else $error("more than one channel ready in the same cycle");

    a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst)
        mem_full |-> !mem_push)
        else $error("mem_push while mem_full is high");

    a_clr_with_push: assert property (@(posedge clk) disable iff (!rst)
        clr_req_stall |-> mem_push)
        else $error("clr_req_stall without mem_push");

endmodule

bind llc_in_arbiter llc_in_arbiter_properties u_props (
    .clk           (clk),
    .rst           (rst),
    .rst_tb_ready  (rst_tb_ready),
    .rsp_ready     (rsp_ready),
    .req_ready     (req_ready),
    .dma_ready     (dma_ready),
    .mem_push      (mem_push),
    .mem_full      (mem_full),
    .clr_req_stall (clr_req_stall)
);

/* llc_in_if.sv */
/* decode queue links between selector, queue and dispatcher
   push must stay low while full is high, pop must stay low while empty is high */
`timescale 1ns/10ps

// write side of the decode queue
interface decode_push_if;
    logic                      push;  // write entry at this edge
    logic                      full;
    llc_in_pkg::decode_entry_t entry;

    modport source (
        output push,
        output entry,
        input  full
    );

    modport sink (
        input  push,
        input  entry,
        output full
    );
endinterface

// read side of the decode queue, head valid while empty is low
interface decode_pop_if;
    logic                      pop;
    logic                      empty;
    llc_in_pkg::decode_entry_t head;

    modport source (
        input  pop,
        output empty,
        output head
    );

    modport sink (
        output pop,
        input  empty,
        input  head
    );
endinterface

/* llc_in_pkg.sv */
/* shared geometry and types for the llc input stage
   set is the low part of the line address, tag the part above it */
package llc_in_pkg;

    // line address geometry
    localparam int LINE_ADDR_BITS = 28;
    localparam int SET_BITS       = 8;
    localparam int TAG_BITS       = LINE_ADDR_BITS - SET_BITS; // 20

    // sizes of the decode queue and the in-flight set table
    localparam int DECODE_DEPTH      = 2;
    localparam int SET_TABLE_ENTRIES = 4;

    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [SET_BITS-1:0]       llc_set_t;
    typedef logic [TAG_BITS-1:0]       llc_tag_t;

    // input channels, listed in priority order
    typedef enum logic [1:0] {
        CH_RST = 2'd0,  // reset from the testbench side
        CH_RSP = 2'd1,  // coherence response
        CH_REQ = 2'd2,  // coherence request
        CH_DMA = 2'd3   // dma request
    } chan_e;

    // one accepted item waiting in the decode queue
    typedef struct packed {
        chan_e      chan;
        line_addr_t addr;
    } decode_entry_t;

endpackage

/* llc_line_dispatch.sv */
/* releases the queue head to memory when there is room and its set is free
   reset entries skip the set table and always go out with tag and set zero */
`timescale 1ns/10ps

module llc_line_dispatch (
    decode_pop_if.sink           pop,
    input  logic                 mem_full,
    input  logic                 req_stall,
    input  llc_in_pkg::llc_tag_t req_stalled_tag,
    input  llc_in_pkg::llc_set_t req_stalled_set,
    input  logic                 hit,
    input  logic                 table_full,
    output llc_in_pkg::llc_set_t lookup_set,
    output logic                 add,
    output logic                 mem_push,
    output llc_in_pkg::chan_e    mem_chan,
    output llc_in_pkg::llc_tag_t mem_tag,
    output llc_in_pkg::llc_set_t mem_set,
    output logic                 clr_req_stall
);

    logic                 is_rst;
    logic                 set_free;
    llc_in_pkg::llc_tag_t head_tag;
    llc_in_pkg::llc_set_t head_set;

    assign is_rst = (pop.head.chan == llc_in_pkg::CH_RST);

    // line address breakdown, set in the low bits
    assign head_tag = is_rst ? '0 :
                      pop.head.addr[llc_in_pkg::LINE_ADDR_BITS-1:llc_in_pkg::SET_BITS];
    assign head_set = is_rst ? '0 : pop.head.addr[llc_in_pkg::SET_BITS-1:0];

    assign lookup_set = head_set;
    assign set_free   = !hit && !table_full;

    // one decision pops the queue, pushes to memory and books the set
    assign mem_push = !pop.empty && !mem_full && (is_rst || set_free);
    assign pop.pop  = mem_push;
    assign add      = mem_push && !is_rst;

    assign mem_chan = pop.head.chan;
    assign mem_tag  = head_tag;
    assign mem_set  = head_set;

    // response for the line the stalled request is waiting on
    assign clr_req_stall = mem_push && req_stall
                        && (pop.head.chan == llc_in_pkg::CH_RSP)
                        && (head_tag == req_stalled_tag)
                        && (head_set == req_stalled_set);

endmodule

/* llc_priority_select.sv */
/* fixed priority reset > response > request > dma, purely combinational
   request and dma are held off while req_stall is high */
`timescale 1ns/10ps

module llc_priority_select (
    input  logic                   rst_tb_valid,
    input  logic                   rsp_valid,
    input  logic                   req_valid,
    input  logic                   dma_valid,
    input  logic                   req_stall,
    input  llc_in_pkg::line_addr_t rsp_addr,
    input  llc_in_pkg::line_addr_t req_addr,
    input  llc_in_pkg::line_addr_t dma_addr,
    output logic                   rst_tb_ready,
    output logic                   rsp_ready,
    output logic                   req_ready,
    output logic                   dma_ready,
    output logic                   idle,
    decode_push_if.source          push
);

    llc_in_pkg::chan_e      sel_chan;
    llc_in_pkg::line_addr_t sel_addr;
    logic                   eligible;  // some channel may be taken this cycle
    logic                   take;

    always_comb begin
        sel_chan = llc_in_pkg::CH_RST;
        sel_addr = '0;
        eligible = 1'b1;
        if (rst_tb_valid) begin
            sel_chan = llc_in_pkg::CH_RST;  // reset carries no address
        end else if (rsp_valid) begin
            sel_chan = llc_in_pkg::CH_RSP;
            sel_addr = rsp_addr;
        end else if (req_valid && !req_stall) begin
            sel_chan = llc_in_pkg::CH_REQ;
            sel_addr = req_addr;
        end else if (dma_valid && !req_stall) begin
            sel_chan = llc_in_pkg::CH_DMA;
            sel_addr = dma_addr;
        end else begin
            eligible = 1'b0;
        end
    end

    // a full queue drops every ready, sources keep valid up
    assign take = eligible && !push.full;
    assign idle = !eligible;

    assign rst_tb_ready = take && (sel_chan == llc_in_pkg::CH_RST);
    assign rsp_ready    = take && (sel_chan == llc_in_pkg::CH_RSP);
    assign req_ready    = take && (sel_chan == llc_in_pkg::CH_REQ);
    assign dma_ready    = take && (sel_chan == llc_in_pkg::CH_DMA);

    assign push.push       = take;
    assign push.entry.chan = sel_chan;
    assign push.entry.addr = sel_addr;

endmodule

/* llc_set_table.sv */
/* sets currently in flight toward memory, lookup is combinational
   add and retire of the same set in one cycle is not supported */
`timescale 1ns/10ps

module llc_set_table #(
    parameter int ENTRIES = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  llc_in_pkg::llc_set_t lookup_set,
    input  llc_in_pkg::llc_set_t add_set,
    input  logic                 add,
    input  logic                 done_valid,
    input  llc_in_pkg::llc_set_t done_set,
    output logic                 hit,
    output logic                 table_full
);

    logic [ENTRIES-1:0]   slot_valid;
    llc_in_pkg::llc_set_t slot_set [ENTRIES];
    logic [ENTRIES-1:0]   add_sel;  // one-hot, first free slot
    logic                 found;

    // pick the lowest free slot
    always_comb begin
        add_sel = '0;
        found   = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (add && !slot_valid[i] && !found) begin
                add_sel[i] = 1'b1;
                found      = 1'b1;
            end
        end
    end

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (slot_valid[i] && (slot_set[i] == lookup_set)) begin
                hit = 1'b1;
            end
        end
    end

    assign table_full = &slot_valid;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < ENTRIES; i++) begin
                if (add_sel[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (done_valid && slot_valid[i] && (slot_set[i] == done_set)) begin
                    slot_valid[i] <= 1'b0;  // retired by the memory stage
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ENTRIES; i++) begin
            if (add_sel[i]) begin
                slot_set[i] <= add_set;
            end
        end
    end

endmodule

/* tb_llc_in_arbiter.sv */
/* sources hold valid and address until ready
   the memory-side model retires sets in order and adds random mem_full when enabled */
`timescale 1ns/10ps

module tb_llc_in_arbiter;

    typedef struct packed {
        llc_in_pkg::chan_e    chan;
        llc_in_pkg::llc_tag_t tag;
        llc_in_pkg::llc_set_t line_set;
        logic                 clr;
    } expect_t;

    logic                      clk;
    logic                      rst;
    logic [3:0]                vld;  // bit 0 is rst, then rsp, req and dma
    logic [3:0]                rdy;
    llc_in_pkg::line_addr_t    addr [4];
    logic                      req_stall;
    llc_in_pkg::llc_tag_t      req_stalled_tag;
    llc_in_pkg::llc_set_t      req_stalled_set;
    logic                      mem_full;
    logic                      done_valid;
    llc_in_pkg::llc_set_t      done_set;
    logic                      mem_push;
    llc_in_pkg::chan_e         mem_chan;
    llc_in_pkg::llc_tag_t      mem_tag;
    llc_in_pkg::llc_set_t      mem_set;
    logic                      clr_req_stall;
    logic                      idle;

    llc_in_pkg::line_addr_t    pend_q [4][$];  // items waiting at each source
    llc_in_pkg::decode_entry_t exp_q [$];      // accepted and not yet pushed
    llc_in_pkg::llc_set_t      in_flight [$];
    llc_in_pkg::llc_set_t      to_retire [$];
    logic [3:0]                acc;
    logic                      hold_retire;
    logic                      full_noise;
    int                        errors;
    int                        checks;
    int                        tests;
    int                        pushed;

    llc_in_arbiter UUT (
        .rst_tb_valid (vld[0]),
        .rsp_valid    (vld[1]),
        .req_valid    (vld[2]),
        .dma_valid    (vld[3]),
        .rst_tb_ready (rdy[0]),
        .rsp_ready    (rdy[1]),
        .req_ready    (rdy[2]),
        .dma_ready    (rdy[3]),
        .rsp_addr     (addr[1]),
        .req_addr     (addr[2]),
        .dma_addr     (addr[3]),
        .*
    );

    always #4 clk = ~clk;

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_chan(input llc_in_pkg::chan_e got, input llc_in_pkg::chan_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns: mem_chan is %s, expected %s", $time, got.name(), exp.name());
        end
    endtask

    task automatic check_tag(input llc_in_pkg::llc_tag_t got, input llc_in_pkg::llc_tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns: mem_tag is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_set(input llc_in_pkg::llc_set_t got, input llc_in_pkg::llc_set_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns: mem_set is %h, expected %h", $time, got, exp);
        end
    endtask

    // expected memory-side view of one accepted item
    function automatic expect_t expect_out(input llc_in_pkg::decode_entry_t item,
                                           input logic stall,
                                           input llc_in_pkg::llc_tag_t stag,
                                           input llc_in_pkg::llc_set_t sset);
        expect_t e;
        e.chan     = item.chan;
        e.tag      = llc_in_pkg::llc_tag_t'(item.addr >> llc_in_pkg::SET_BITS);
        e.line_set = llc_in_pkg::llc_set_t'(item.addr);
        if (item.chan == llc_in_pkg::CH_RST) begin
            e.tag      = '0;
            e.line_set = '0;
        end
        e.clr = stall && (item.chan == llc_in_pkg::CH_RSP)
             && (e.tag == stag) && (e.line_set == sset);
        return e;
    endfunction

    function automatic logic set_free(input llc_in_pkg::llc_set_t s);
        logic free;
        free = (in_flight.size() < llc_in_pkg::SET_TABLE_ENTRIES);
        foreach (in_flight[i]) begin
            if (in_flight[i] == s) begin
                free = 1'b0;
            end
        end
        return free;
    endfunction

    // skip_low leaves request and dma sources out of the check
    function automatic logic busy(input logic skip_low);
        logic b;
        b = (exp_q.size() != 0) || (to_retire.size() != 0);
        for (int c = 0; c < 4; c++) begin
            if (!(skip_low && c >= 2) && (vld[c] || pend_q[c].size() != 0)) begin
                b = 1'b1;
            end
        end
        return b;
    endfunction

    // outputs have settled by the falling edge
    always @(negedge clk) begin : compare
        logic [3:0]                win;
        expect_t                   e;
        llc_in_pkg::decode_entry_t item;
        int                        idx;
        if (rst) begin
            win = '0;
            if (exp_q.size() < llc_in_pkg::DECODE_DEPTH) begin
                if (vld[0]) win[0] = 1'b1;
                else if (vld[1]) win[1] = 1'b1;
                else if (vld[2] && !req_stall) win[2] = 1'b1;
                else if (vld[3] && !req_stall) win[3] = 1'b1;
            end
            for (int c = 0; c < 4; c++) begin
                check_bit(rdy[c], win[c], $sformatf("ready of channel %0d", c));
            end
            check_bit(idle, !(vld[0] || vld[1] || ((vld[2] || vld[3]) && !req_stall)), "idle");
            if (mem_push && exp_q.size() == 0) begin
                errors++;
                $display("mem_push at %0t ns with no accepted item waiting", $time);
            end else if (mem_push) begin
                item = exp_q.pop_front();
                e = expect_out(item, req_stall, req_stalled_tag, req_stalled_set);
                check_chan(mem_chan, e.chan);
                check_tag(mem_tag, e.tag);
                check_set(mem_set, e.line_set);
                check_bit(clr_req_stall, e.clr, "clr_req_stall");
                check_bit(mem_full, 1'b0, "mem_full during mem_push");
                if (e.chan != llc_in_pkg::CH_RST) begin
                    check_bit(set_free(e.line_set), 1'b1, "set free at dispatch");
                    in_flight.push_back(e.line_set);
                    to_retire.push_back(e.line_set);
                end
                pushed++;
            end else begin
                check_bit(clr_req_stall, 1'b0, "clr_req_stall without mem_push");
            end
            idx = -1;
            foreach (in_flight[i]) begin
                if (done_valid && in_flight[i] == done_set) idx = i;
            end
            if (idx >= 0) in_flight.delete(idx);
            for (int c = 0; c < 4; c++) begin
                if (rdy[c] && vld[c]) begin
                    item.chan = llc_in_pkg::chan_e'(2'(c));
                    item.addr = (c == 0) ? '0 : addr[c];
                    exp_q.push_back(item);
                    acc[c] = 1'b1;
                end
            end
        end
    end

    always begin : source_drive
        @(posedge clk);
        #1;
        for (int c = 0; c < 4; c++) begin
            if (vld[c] && acc[c]) vld[c] = 1'b0;
            acc[c] = 1'b0;
            if (!vld[c] && pend_q[c].size() != 0) begin
                vld[c]  = 1'b1;
                addr[c] = pend_q[c].pop_front();
            end
        end
    end

    always begin : memory_side
        @(posedge clk);
        #1;
        done_valid = 1'b0;
        if (!hold_retire && to_retire.size() != 0 && ($urandom % 2 == 0)) begin
            done_valid = 1'b1;
            done_set   = to_retire.pop_front();
        end
        mem_full = full_noise && ($urandom % 3 == 0);
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic send_random(input int n, input int set_range);
        int                     c;
        llc_in_pkg::line_addr_t a;
        for (int i = 0; i < n; i++) begin
            c = ($urandom % 8 == 0) ? 0 : 1 + ($urandom % 3);
            a = llc_in_pkg::line_addr_t'($urandom);
            if (set_range > 0) begin
                a[llc_in_pkg::SET_BITS-1:0] = llc_in_pkg::llc_set_t'($urandom % set_range);
            end
            pend_q[c].push_back(a);
        end
    endtask

    task automatic abort(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic wait_quiet(input logic skip_low, input int limit, input string what);
        int n;
        n = 0;
        while (busy(skip_low) && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (busy(skip_low)) abort($sformatf("timeout: %s not drained in %0d cycles", what, limit));
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    endtask

    initial begin
        int e0;
        int base;
        int n;
        void'($urandom(32'h69773754));
        clk = 1'b0;
        rst = 1'b0;
        vld = '0;
        acc = '0;
        foreach (addr[c]) addr[c] = '0;
        req_stall = 1'b0;
        req_stalled_tag = '0;
        req_stalled_set = '0;
        mem_full = 1'b0;
        done_valid = 1'b0;
        done_set = '0;
        hold_retire = 1'b0;
        full_noise = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        pushed = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;

        e0 = errors;
        @(negedge clk);
        check_bit(|rdy, 1'b0, "any ready after reset");
        check_bit(mem_push, 1'b0, "mem_push after reset");
        check_bit(clr_req_stall, 1'b0, "clr_req_stall after reset");
        end_test("quiet after reset", e0);

        e0 = errors;
        tick();
        for (int c = 3; c >= 0; c--) pend_q[c].push_back(llc_in_pkg::line_addr_t'($urandom));
        pend_q[1].push_back(llc_in_pkg::line_addr_t'($urandom));
        wait_quiet(1'b0, 200, "priority traffic");
        end_test("priority order", e0);

        e0 = errors;
        tick();
        pend_q[0].push_back('0);
        send_random(24, 0);
        wait_quiet(1'b0, 400, "random addresses");
        end_test("address breakdown", e0);

        e0 = errors;
        tick();
        hold_retire = 1'b1;
        base = pushed;
        pend_q[1].push_back({20'h01234, 8'h5a});
        pend_q[1].push_back({20'h09876, 8'h5a});
        n = 0;
        while (pushed == base && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (pushed == base) abort("timeout: first line of the shared set never pushed");
        repeat (8) @(posedge clk);
        check_bit(pushed == base + 1, 1'b1, "second line held behind its set");
        tick();
        hold_retire = 1'b0;
        wait_quiet(1'b0, 200, "set conflict");
        end_test("same set ordering", e0);

        e0 = errors;
        tick();
        req_stall = 1'b1;
        req_stalled_tag = 20'h0abcd;
        req_stalled_set = 8'h33;
        pend_q[2].push_back(llc_in_pkg::line_addr_t'($urandom));
        pend_q[3].push_back(llc_in_pkg::line_addr_t'($urandom));
        pend_q[1].push_back({20'h0abcd, 8'h34});
        pend_q[1].push_back({20'h0abcd, 8'h33});  // the one that clears the stall
        pend_q[0].push_back('0);
        pend_q[1].push_back({20'h0abce, 8'h33});
        wait_quiet(1'b1, 200, "responses under stall");
        check_bit(vld[2] && vld[3], 1'b1, "request and dma still waiting");
        tick();
        req_stall = 1'b0;
        wait_quiet(1'b0, 200, "stall release");
        end_test("request stall", e0);

        e0 = errors;
        tick();
        full_noise = 1'b1;
        send_random(40, 4);
        wait_quiet(1'b0, 1500, "back-pressure traffic");
        tick();
        full_noise = 1'b0;
        end_test("mem_full back-pressure", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
